// ==== vlog.f ====
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/pipeline_top.sv
verif/pipeline_asserts.sv
verif/pipeline_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipeline_tb
FILELIST  = vlog.f
OBJDIR    = obj_dir

SOURCES   = $(shell cat $(FILELIST))
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== verif/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb import cpu_pkg::*; ();

	localparam int imem_addr_width = 7;
	localparam int num_tests       = 6;
	localparam int prog_len        = 16;
	localparam int run_cycles      = 40;
	localparam int cycles_per_test = 2 + prog_len + run_cycles + 6;
	localparam int cycle_limit     = num_tests * cycles_per_test;
	localparam int lcg_test        = 1;     // Expected values come from the model

	typedef struct packed {
		word_t [prog_len-1:0] prog;
		reg_idx_t [3:0]       chk_reg;
		word_t [3:0]          chk_val;
		logic [2:0]           n_chk;
		word_t                n_writes;
	} test_t;

	logic                       clk;
	logic                       reset;
	logic                       load_mode;
	logic                       load_we;
	logic [imem_addr_width-1:0] load_addr;
	word_t                      load_data;
	reg_idx_t                   dbg_reg_addr;
	wb_t                        wb;
	word_t                      dbg_reg_data;
	logic                       halted;

	test_t tests [num_tests];
	string test_names [num_tests];
	int    instr_count [num_tests];
	word_t model_regs [32];
	wb_t   exp_wb [$];
	word_t lcg_state = 32'd51;
	string cur_name;
	int    errors = 0;
	int    checks = 0;
	int    cycle_count;

	pipeline_top #(
		.imem_addr_width(imem_addr_width)
	) i_pipeline_top (
		.clk         (clk),
		.reset       (reset),
		.load_mode   (load_mode),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.dbg_reg_addr(dbg_reg_addr),
		.wb          (wb),
		.dbg_reg_data(dbg_reg_data),
		.halted      (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////
	// Instruction encoders

	function automatic word_t r_word(input logic [5:0] funct, input reg_idx_t rs,
		input reg_idx_t rt, input reg_idx_t rd);
		instr_u w;
		w = '0;
		w.r_view.rs    = rs;
		w.r_view.rt    = rt;
		w.r_view.rd    = rd;
		w.r_view.funct = funct;
		return w;
	endfunction

	function automatic word_t i_word(input logic [5:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [15:0] imm);
		instr_u w;
		w.i_view.opcode = op;
		w.i_view.rs     = rs;
		w.i_view.rt     = rt;
		w.i_view.imm    = imm;
		return w;
	endfunction

	function automatic word_t j_word(input logic [25:0] target);
		instr_u w;
		w.j_view.opcode = op_j;
		w.j_view.target = target;      // Word index
		return w;
	endfunction

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic append_instr(input int t, input word_t w);
		tests[t].prog[instr_count[t]] = w;
		instr_count[t]++;
	endtask

	task automatic expect_reg(input int t, input reg_idx_t r, input word_t v);
		tests[t].chk_reg[tests[t].n_chk] = r;
		tests[t].chk_val[tests[t].n_chk] = v;
		tests[t].n_chk = tests[t].n_chk + 3'd1;
	endtask

	//////////////////////////////
	// Program table

	task automatic build_table();
		word_t halt_w;
		halt_w = i_word(op_halt, 5'd0, 5'd0, 16'd0);
		for (int t = 0; t < num_tests; t++)
		begin
			tests[t] = '0;
			instr_count[t] = 0;
		end

		test_names[0] = "alu_fwd";     // Back-to-back dependencies
		append_instr(0, i_word(op_addi, 5'd0, 5'd1, 16'd5));
		append_instr(0, i_word(op_addi, 5'd1, 5'd2, 16'd7));
		append_instr(0, r_word(fn_add, 5'd1, 5'd2, 5'd3));
		append_instr(0, r_word(fn_sub, 5'd3, 5'd1, 5'd4));
		append_instr(0, r_word(fn_and, 5'd4, 5'd3, 5'd5));
		append_instr(0, r_word(fn_or, 5'd4, 5'd3, 5'd6));
		append_instr(0, r_word(fn_slt, 5'd1, 5'd4, 5'd7));
		append_instr(0, i_word(op_addi, 5'd0, 5'd8, 16'hfffd));
		append_instr(0, r_word(fn_slt, 5'd8, 5'd1, 5'd9));     // Signed compare
		append_instr(0, halt_w);
		expect_reg(0, 5'd3, 32'd17);
		expect_reg(0, 5'd4, 32'd12);
		expect_reg(0, 5'd6, 32'd29);
		expect_reg(0, 5'd9, 32'd1);
		tests[0].n_writes = 32'd9;

		// Bit 15 forced so extension shows in the upper half
		test_names[1] = "imm_lcg";
		append_instr(1, i_word(op_addi, 5'd0, 5'd1, lcg_next() | 16'h8000));
		append_instr(1, i_word(op_addi, 5'd1, 5'd2, lcg_next()));
		append_instr(1, i_word(op_andi, 5'd2, 5'd3, lcg_next() | 16'h8000));
		append_instr(1, i_word(op_ori, 5'd0, 5'd4, lcg_next() | 16'h8000));
		append_instr(1, i_word(op_ori, 5'd3, 5'd5, lcg_next()));
		append_instr(1, i_word(op_addi, 5'd5, 5'd6, lcg_next()));
		append_instr(1, halt_w);
		expect_reg(1, 5'd2, '0);
		expect_reg(1, 5'd3, '0);
		expect_reg(1, 5'd4, '0);
		expect_reg(1, 5'd6, '0);

		test_names[2] = "branches";
		append_instr(2, i_word(op_addi, 5'd0, 5'd1, 16'd3));
		append_instr(2, i_word(op_addi, 5'd0, 5'd2, 16'd3));
		append_instr(2, i_word(op_beq, 5'd1, 5'd2, 16'd2));     // Taken
		append_instr(2, i_word(op_addi, 5'd0, 5'd3, 16'd1));
		append_instr(2, i_word(op_addi, 5'd0, 5'd4, 16'd1));
		append_instr(2, i_word(op_bne, 5'd1, 5'd2, 16'd2));     // Not taken
		append_instr(2, i_word(op_addi, 5'd0, 5'd5, 16'd7));
		append_instr(2, i_word(op_bne, 5'd1, 5'd5, 16'd1));     // Taken, r5 forwarded
		append_instr(2, i_word(op_addi, 5'd0, 5'd6, 16'd9));
		append_instr(2, i_word(op_beq, 5'd1, 5'd5, 16'd5));
		append_instr(2, i_word(op_addi, 5'd0, 5'd7, 16'd11));
		append_instr(2, halt_w);
		expect_reg(2, 5'd3, 32'd0);
		expect_reg(2, 5'd5, 32'd7);
		expect_reg(2, 5'd6, 32'd0);
		expect_reg(2, 5'd7, 32'd11);
		tests[2].n_writes = 32'd4;

		test_names[3] = "jump";
		append_instr(3, i_word(op_addi, 5'd0, 5'd1, 16'd1));
		append_instr(3, j_word(26'd3));
		append_instr(3, i_word(op_addi, 5'd1, 5'd1, 16'd100));
		append_instr(3, i_word(op_addi, 5'd1, 5'd2, 16'd2));
		append_instr(3, j_word(26'd6));
		append_instr(3, i_word(op_addi, 5'd0, 5'd3, 16'd5));
		append_instr(3, halt_w);
		expect_reg(3, 5'd1, 32'd1);
		expect_reg(3, 5'd2, 32'd3);
		expect_reg(3, 5'd3, 32'd0);
		tests[3].n_writes = 32'd2;

		test_names[4] = "reg_zero";
		append_instr(4, i_word(op_addi, 5'd0, 5'd0, 16'd55));
		append_instr(4, i_word(op_addi, 5'd0, 5'd1, 16'd4));
		append_instr(4, r_word(fn_add, 5'd1, 5'd1, 5'd0));
		append_instr(4, r_word(fn_add, 5'd0, 5'd1, 5'd2));
		append_instr(4, r_word(fn_or, 5'd0, 5'd0, 5'd3));
		append_instr(4, halt_w);
		expect_reg(4, 5'd0, 32'd0);
		expect_reg(4, 5'd1, 32'd4);
		expect_reg(4, 5'd2, 32'd4);
		expect_reg(4, 5'd3, 32'd0);
		tests[4].n_writes = 32'd3;

		test_names[5] = "halt_stop";
		append_instr(5, i_word(op_addi, 5'd0, 5'd1, 16'd9));
		append_instr(5, i_word(op_addi, 5'd1, 5'd2, 16'd1));
		append_instr(5, halt_w);
		append_instr(5, i_word(op_addi, 5'd0, 5'd3, 16'd77));   // Must never retire
		append_instr(5, i_word(op_addi, 5'd0, 5'd1, 16'd0));
		expect_reg(5, 5'd1, 32'd9);
		expect_reg(5, 5'd2, 32'd10);
		expect_reg(5, 5'd3, 32'd0);
		tests[5].n_writes = 32'd2;
	endtask

	//////////////////////////////
	// Reference model, one instruction at a time

	task automatic run_model(input int t);
		word_t    pc;
		instr_u   ins;
		word_t    simm;
		word_t    zimm;
		word_t    res;
		reg_idx_t dest;
		logic     wr;
		logic     taken;
		logic     done;
		int       steps;
		wb_t      rec;
		exp_wb.delete();
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		pc    = '0;
		steps = 0;
		done  = 1'b0;
		while (!done && steps < 64 && pc < prog_len * 4)
		begin
			ins  = tests[t].prog[pc[5:2]];
			simm = {{16{ins.i_view.imm[15]}}, ins.i_view.imm};
			zimm = {16'h0000, ins.i_view.imm};
			dest = ins.i_view.rt;
			wr   = 1'b1;
			res  = '0;
			pc   = pc + 32'd4;
			steps++;
			case (ins.r_view.opcode)
				op_halt:
				begin
					done = 1'b1;
					wr   = 1'b0;
				end
				op_j:
				begin
					pc = {pc[31:28], ins.j_view.target, 2'b00};
					wr = 1'b0;
				end
				op_beq, op_bne:
				begin
					taken = (model_regs[ins.i_view.rs] == model_regs[ins.i_view.rt]);
					if (ins.r_view.opcode == op_bne)
						taken = !taken;
					if (taken)
						pc = pc + (simm << 2);
					wr = 1'b0;
				end
				op_addi: res = model_regs[ins.i_view.rs] + simm;
				op_andi: res = model_regs[ins.i_view.rs] & zimm;
				op_ori:  res = model_regs[ins.i_view.rs] | zimm;
				op_rtype:
				begin
					dest = ins.r_view.rd;
					case (ins.r_view.funct)
						fn_add:  res = model_regs[ins.r_view.rs] + model_regs[ins.r_view.rt];
						fn_sub:  res = model_regs[ins.r_view.rs] - model_regs[ins.r_view.rt];
						fn_and:  res = model_regs[ins.r_view.rs] & model_regs[ins.r_view.rt];
						fn_or:   res = model_regs[ins.r_view.rs] | model_regs[ins.r_view.rt];
						fn_slt:  res = ($signed(model_regs[ins.r_view.rs]) <
							$signed(model_regs[ins.r_view.rt])) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				default: wr = 1'b0;
			endcase
			if (wr && dest != '0)     // Writes to r0 vanish
			begin
				model_regs[dest] = res;
				rec.we    = 1'b1;
				rec.dest  = dest;
				rec.value = res;
				exp_wb.push_back(rec);
			end
		end
	endtask

	//////////////////////////////
	// Compare tasks

	task automatic check_word(input string what, input word_t got, input word_t want);
		checks++;
		if (got !== want)
		begin
			$display("[FAIL] %0t ns, test %s: %s is %h, expected %h",
				$time, cur_name, what, got, want);
			errors++;
		end
	endtask

	task automatic check_wb(input int idx, input wb_t got, input wb_t want);
		checks++;
		if (got.dest !== want.dest || got.value !== want.value)
		begin
			$display("[FAIL] %0t ns, test %s: write %0d is r%0d=%h, expected r%0d=%h",
				$time, cur_name, idx, got.dest, got.value, want.dest, want.value);
			errors++;
		end
	endtask

	initial
	begin
		int got;
		int errors_before;
		reset        = 1'b1;
		load_mode    = 1'b1;
		load_we      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		dbg_reg_addr = '0;
		build_table();

		for (int t = 0; t < num_tests; t++)
		begin
			cur_name      = test_names[t];
			errors_before = errors;
			run_model(t);
			if (t == lcg_test)
			begin
				for (int k = 0; k < tests[t].n_chk; k++)
					tests[t].chk_val[k] = model_regs[tests[t].chk_reg[k]];
				tests[t].n_writes = exp_wb.size();
			end

			@(negedge clk);
			reset     = 1'b1;
			load_mode = 1'b1;
			load_we   = 1'b0;
			repeat (2) @(negedge clk);
			reset = 1'b0;

			// Whole table slot, so leftovers of an older program are overwritten
			for (int i = 0; i < prog_len; i++)
			begin
				load_we   = 1'b1;
				load_addr = imem_addr_width'(i);
				load_data = tests[t].prog[i];
				@(negedge clk);
			end
			load_we   = 1'b0;
			load_mode = 1'b0;

			got = 0;
			while (!halted)
			begin
				@(negedge clk);
				if (wb.we)
				begin
					if (exp_wb.size() == 0)
					begin
						$display("Test %s: unexpected extra write to r%0d", cur_name, wb.dest);
						errors++;
					end
					else
						check_wb(got, wb, exp_wb.pop_front());
					got++;
				end
			end
			check_word("write count", word_t'(got), tests[t].n_writes);

			for (int k = 0; k < tests[t].n_chk; k++)
			begin
				dbg_reg_addr = tests[t].chk_reg[k];
				@(negedge clk);
				check_word($sformatf("r%0d", tests[t].chk_reg[k]), dbg_reg_data,
					tests[t].chk_val[k]);
				if (!halted || wb.we)
				begin
					$display("Test %s: halted dropped or a write retired after halt", cur_name);
					errors++;
				end
			end
			$display("test %-10s %0d writes, %0d mismatches", cur_name, got,
				errors - errors_before);
		end

		$display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/pipeline_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_asserts import cpu_pkg::*; (
	input logic      clk,
	input logic      reset,
	input logic      load_mode,
	input logic      halted,
	input wb_t       wb,
	input word_t     r0_value,
	input redirect_t branch_redirect
);

	// Halted is sticky until the next reset
	halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
		else $error("halted fell without a reset");

	// Stored register 0 stays zero whatever retires
	no_r0_write: assert property (@(posedge clk) disable iff (reset) r0_value == '0)
		else $error("register 0 holds a nonzero value");

	quiet_when_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !wb.we)
		else $error("write strobe while halted");

	// Pipeline is empty while the program loads
	no_branch_in_load: assert property (@(posedge clk) disable iff (reset)
		load_mode |-> !branch_redirect.taken)
		else $error("branch redirect during load mode");

endmodule

bind pipeline_top pipeline_asserts i_pipeline_asserts (
	.clk            (clk),
	.reset          (reset),
	.load_mode      (load_mode),
	.halted         (halted),
	.wb             (wb),
	.r0_value       (i_register_file.regs[0]),
	.branch_redirect(branch_redirect)
);

`default_nettype wire

// ==== verilog/pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top import cpu_pkg::*; #(
	parameter int imem_addr_width = 7
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load_mode,
	input  logic                       load_we,
	input  logic [imem_addr_width-1:0] load_addr,
	input  word_t                      load_data,
	input  reg_idx_t                   dbg_reg_addr,
	output wb_t                        wb,
	output word_t                      dbg_reg_data,
	output logic                       halted
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_wb_t    ex_wb;
	redirect_t jump_redirect;
	redirect_t branch_redirect;
	logic      halt_seen;
	reg_idx_t  rs_idx;
	reg_idx_t  rt_idx;
	word_t     rs_data;
	word_t     rt_data;

	fetch_stage #(
		.imem_addr_width(imem_addr_width)
	) i_fetch_stage (
		.clk            (clk),
		.reset          (reset),
		.load_mode      (load_mode),
		.load_we        (load_we),
		.load_addr      (load_addr),
		.load_data      (load_data),
		.jump_redirect  (jump_redirect),
		.branch_redirect(branch_redirect),
		.halt_seen      (halt_seen),
		.if_id          (if_id)
	);

	decode_stage i_decode_stage (
		.clk            (clk),
		.reset          (reset),
		.if_id          (if_id),
		.rs_data        (rs_data),
		.rt_data        (rt_data),
		.branch_redirect(branch_redirect),
		.rs_idx         (rs_idx),
		.rt_idx         (rt_idx),
		.jump_redirect  (jump_redirect),
		.halt_seen      (halt_seen),
		.id_ex          (id_ex)
	);

	register_file i_register_file (
		.clk     (clk),
		.reset   (reset),
		.wb      (wb),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.dbg_idx (dbg_reg_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.dbg_data(dbg_reg_data)
	);

	execute_stage i_execute_stage (
		.clk            (clk),
		.reset          (reset),
		.id_ex          (id_ex),
		.fwd            (wb),            // Result stage value bypass
		.branch_redirect(branch_redirect),
		.ex_wb          (ex_wb)
	);

	result_stage i_result_stage (
		.clk   (clk),
		.reset (reset),
		.ex_wb (ex_wb),
		.wb    (wb),
		.halted(halted)
	);

endmodule

`default_nettype wire

// ==== verilog/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage import cpu_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  ex_wb_t ex_wb,
	output wb_t    wb,
	output logic   halted
);

	// Register 0 never gets a strobe
	assign wb.we    = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest != '0);
	assign wb.dest  = ex_wb.dest;
	assign wb.value = ex_wb.value;

	// Sticky until reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			halted <= 1'b0;
		else if (ex_wb.valid && ex_wb.is_halt)
			halted <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  id_ex_t    id_ex,
	input  wb_t       fwd,
	output redirect_t branch_redirect,
	output ex_wb_t    ex_wb
);

	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_out;
	logic  equal;

	//////////////////////////////
	// Forwarding from result stage

	always_comb
	begin
		op_a = id_ex.a;
		op_b = id_ex.b;
		if (fwd.we && fwd.dest != '0 && fwd.dest == id_ex.rs)
			op_a = fwd.value;
		if (fwd.we && fwd.dest != '0 && fwd.dest == id_ex.rt)
			op_b = fwd.value;
	end

	assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

	always_comb
	begin
		case (id_ex.alu_op)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or:  alu_out = op_a | alu_b;
			alu_slt: alu_out = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////
	// Branch resolution

	assign equal = (op_a == op_b);

	assign branch_redirect.taken  = id_ex.valid &&
		((id_ex.is_beq && equal) || (id_ex.is_bne && !equal));
	assign branch_redirect.target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_wb <= '0;
		else
		begin
			ex_wb.valid     <= id_ex.valid;
			ex_wb.dest      <= id_ex.dest;
			ex_wb.reg_write <= id_ex.reg_write;
			ex_wb.value     <= alu_out;
			ex_wb.is_halt   <= id_ex.is_halt;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  if_id_t    if_id,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  redirect_t branch_redirect,
	output reg_idx_t  rs_idx,
	output reg_idx_t  rt_idx,
	output redirect_t jump_redirect,
	output logic      halt_seen,
	output id_ex_t    id_ex
);

	instr_u     ins;
	logic [5:0] opcode;
	word_t      pc_plus4;
	id_ex_t     d;
	logic       halt_hold;      // A halt has already gone on to execute

	assign ins      = if_id.instr;
	assign opcode   = ins.r_view.opcode;
	assign pc_plus4 = if_id.pc + 32'd4;

	assign rs_idx = ins.i_view.rs;
	assign rt_idx = ins.i_view.rt;

	//////////////////////////////
	// Jump and halt

	assign jump_redirect.taken  = if_id.valid && (opcode == op_j);
	assign jump_redirect.target = {pc_plus4[31:28], ins.j_view.target, 2'b00};

	assign halt_seen = (if_id.valid && (opcode == op_halt)) || halt_hold;

	//////////////////////////////
	// Field decode

	always_comb
	begin
		d           = '0;
		d.valid     = if_id.valid && !branch_redirect.taken;  // Squash behind a branch
		d.a         = rs_data;
		d.b         = rt_data;
		d.rs        = ins.i_view.rs;
		d.rt        = ins.i_view.rt;
		d.pc_plus4  = pc_plus4;
		d.alu_op    = alu_add;
		d.dest      = ins.i_view.rt;
		d.imm       = {{16{ins.i_view.imm[15]}}, ins.i_view.imm};
		case (opcode)
			op_rtype:
			begin
				d.dest      = ins.r_view.rd;
				d.reg_write = 1'b1;
				case (ins.r_view.funct)
					fn_add:  d.alu_op = alu_add;
					fn_sub:  d.alu_op = alu_sub;
					fn_and:  d.alu_op = alu_and;
					fn_or:   d.alu_op = alu_or;
					fn_slt:  d.alu_op = alu_slt;
					default: d.reg_write = 1'b0;     // Unknown funct
				endcase
			end
			op_addi:
			begin
				d.use_imm   = 1'b1;
				d.reg_write = 1'b1;
			end
			op_andi, op_ori:
			begin
				d.use_imm   = 1'b1;
				d.reg_write = 1'b1;
				d.imm       = {16'h0000, ins.i_view.imm};     // Logical ops zero-extend
				d.alu_op    = (opcode == op_andi) ? alu_and : alu_or;
			end
			op_beq:  d.is_beq  = 1'b1;
			op_bne:  d.is_bne  = 1'b1;
			op_halt: d.is_halt = 1'b1;
			default: ;                                    // Jump or unknown, no effect downstream
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			id_ex     <= '0;
			halt_hold <= 1'b0;
		end
		else
		begin
			id_ex <= d;
			if (d.valid && d.is_halt)
				halt_hold <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  wb_t      wb,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	input  reg_idx_t dbg_idx,
	output word_t    rs_data,
	output word_t    rt_data,
	output word_t    dbg_data
);

	word_t regs [32];

	// Write-through so decode sees a value retiring this cycle
	function automatic word_t read_port(input reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wb.we && wb.dest == idx)
			return wb.value;
		return regs[idx];
	endfunction

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.we && wb.dest != '0)
			regs[wb.dest] <= wb.value;
	end

	assign rs_data  = read_port(rs_idx);
	assign rt_data  = read_port(rt_idx);
	assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];   // Plain array read

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
	parameter int imem_addr_width = 7
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load_mode,
	input  logic                       load_we,
	input  logic [imem_addr_width-1:0] load_addr,
	input  word_t                      load_data,
	input  redirect_t                  jump_redirect,
	input  redirect_t                  branch_redirect,
	input  logic                       halt_seen,
	output if_id_t                     if_id
);

	word_t  pc;
	word_t  pc_next;
	word_t  pc_plus4;
	instr_u fetched;
	logic   bubble;

	word_t imem [2**imem_addr_width];

	//////////////////////////////
	// Instruction memory

	// Load port only writes while load mode is held
	always_ff @(posedge clk)
	begin
		if (load_mode && load_we)
			imem[load_addr] <= load_data;
	end

	assign fetched = imem[pc[imem_addr_width+1:2]];     // Word index of the PC

	//////////////////////////////
	// Program counter

	assign pc_plus4 = pc + 32'd4;

	always_comb
	begin
		if (load_mode)
			pc_next = '0;                                 // Restart from 0 after load
		else if (branch_redirect.taken)
			pc_next = branch_redirect.target;
		else if (jump_redirect.taken)
			pc_next = jump_redirect.target;
		else if (halt_seen)
			pc_next = pc;                                 // Freeze behind a halt
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// Word fetched this cycle is dropped on any redirect or halt
	assign bubble = load_mode | branch_redirect.taken | jump_redirect.taken | halt_seen;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			if_id <= '0;
		else
		begin
			if_id.valid <= ~bubble;
			if_id.pc    <= pc;
			if_id.instr <= fetched;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	//////////////////////////////
	// Instruction word views

	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;       // Not decoded, no shifts
		logic [5:0] funct;
	} r_view_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_view_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
		j_view_t j_view;
	} instr_u;

	// Opcodes
	localparam logic [5:0] op_rtype = 6'd0;
	localparam logic [5:0] op_j     = 6'd2;
	localparam logic [5:0] op_beq   = 6'd4;
	localparam logic [5:0] op_bne   = 6'd5;
	localparam logic [5:0] op_addi  = 6'd8;
	localparam logic [5:0] op_andi  = 6'd12;
	localparam logic [5:0] op_ori   = 6'd13;
	localparam logic [5:0] op_halt  = 6'd63;

	// R-type funct field
	localparam logic [5:0] fn_add = 6'd32;
	localparam logic [5:0] fn_sub = 6'd34;
	localparam logic [5:0] fn_and = 6'd36;
	localparam logic [5:0] fn_or  = 6'd37;
	localparam logic [5:0] fn_slt = 6'd42;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	//////////////////////////////
	// Pipeline registers

	typedef struct packed {
		logic   valid;
		word_t  pc;
		instr_u instr;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		word_t    a;
		word_t    b;
		reg_idx_t rs;
		reg_idx_t rt;
		logic     use_imm;
		word_t    imm;         // Already extended
		reg_idx_t dest;
		logic     reg_write;
		logic     is_beq;
		logic     is_bne;
		logic     is_halt;
		word_t    pc_plus4;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		logic     reg_write;
		word_t    value;
		logic     is_halt;
	} ex_wb_t;

	// Register write bundle, also the forward path
	typedef struct packed {
		logic     we;
		reg_idx_t dest;
		word_t    value;
	} wb_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire
